// File: design/lsu_consts.svh
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// Data SRAM geometry and response latencies.
`define DSRAM_AW     8         // 256 words, 1 KiB.
`define RC_LAT       3
`define WC_LAT       2

// Major opcodes of the two instruction classes.
`define OPC_LOAD     7'b0000011
`define OPC_STORE    7'b0100011

`define F3_LB        3'b000
`define F3_LH        3'b001
`define F3_LW        3'b010
`define F3_LBU       3'b100
`define F3_LHU       3'b101
`define F3_SB        3'b000
`define F3_SH        3'b001
`define F3_SW        3'b010

`define RESP_OKAY    2'b00
`define RESP_SLVERR  2'b10

`endif

// File: design/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

  typedef logic [31:0] xlen_t;  // Register and data word.
  typedef logic [31:0] addr_t;  // Byte address.
  typedef logic [3:0]  strb_t;
  typedef logic [31:0] inst_t;
  typedef logic [1:0]  resp_t;

  // Encoded to match funct3[1:0] of the access.
  typedef enum logic [1:0] {
    SZ_BYTE = 2'd0,
    SZ_HALF = 2'd1,
    SZ_WORD = 2'd2
  } mem_size_e;

  typedef enum logic [2:0] {
    E_IDLE,
    E_RADDR,
    E_RDATA,
    E_WRITE,   // AW and W in flight together.
    E_WRESP,
    E_FINISH
  } exec_state_e;

  typedef enum logic [2:0] {
    IDLE        = 3'b000,
    READ        = 3'b001,
    WAIT_RREADY = 3'b010,
    WAIT_WVALID = 3'b011,
    WRITE       = 3'b100,
    WAIT_BREADY = 3'b101
  } dsram_state_e;

  typedef enum logic [1:0] {D_IDLE, D_BUSY, D_ACK} dec_state_e;

endpackage

`default_nettype wire

// File: design/lsu_ifs.sv
`default_nettype none

// One decoded memory operation, decode to execute.
interface lsu_op_if;
  logic               valid;
  logic               is_store;
  lsu_pkg::addr_t     addr;
  lsu_pkg::xlen_t     wdata;
  lsu_pkg::strb_t     wstrb;
  lsu_pkg::mem_size_e size;
  logic               uns;
  logic               err;

  modport producer (output valid, is_store, addr, wdata, wstrb, size, uns, err);
  modport consumer (input  valid, is_store, addr, wdata, wstrb, size, uns, err);
endinterface

// A finished access, execute to result.
interface lsu_res_if;
  logic               valid;
  lsu_pkg::xlen_t     rword;
  logic [1:0]         addr_lo;  // Byte offset inside the word.
  lsu_pkg::mem_size_e size;
  logic               uns;
  logic               err;

  modport producer (output valid, rword, addr_lo, size, uns, err);
  modport consumer (input  valid, rword, addr_lo, size, uns, err);
endinterface

// AXI-lite with the five usual channels.
interface mem_bus_if;
  lsu_pkg::addr_t araddr;
  logic           arvalid, arready;
  lsu_pkg::xlen_t rdata;
  lsu_pkg::resp_t rresp;
  logic           rvalid, rready;
  lsu_pkg::addr_t awaddr;
  logic           awvalid, awready;
  lsu_pkg::xlen_t wdata;
  lsu_pkg::strb_t wstrb;
  logic           wvalid, wready;
  lsu_pkg::resp_t bresp;
  logic           bvalid, bready;

  modport master (output araddr, arvalid, rready, awaddr, awvalid, wdata, wstrb, wvalid,
                  bready,
                  input  arready, rdata, rresp, rvalid, awready, wready, bresp, bvalid);
  modport slave  (input  araddr, arvalid, rready, awaddr, awvalid, wdata, wstrb, wvalid,
                  bready,
                  output arready, rdata, rresp, rvalid, awready, wready, bresp, bvalid);
endinterface

`default_nettype wire

// File: design/lsu_decode.sv
`include "lsu_consts.svh"
`default_nettype none

module lsu_decode (
  input  logic           clk,
  input  logic           rst,
  input  logic           cmd_req_i,
  output logic           cmd_ack_o,
  input  lsu_pkg::inst_t inst_i,
  input  lsu_pkg::xlen_t rs1_i,
  input  lsu_pkg::xlen_t rs2_i,
  input  logic           done_i,
  lsu_op_if.producer     op
);

  lsu_pkg::dec_state_e state;
  logic [6:0]          opcode;
  logic [2:0]          funct3;
  logic                is_load, is_store;
  logic                legal, misaligned;
  lsu_pkg::xlen_t      imm;
  lsu_pkg::addr_t      addr;
  lsu_pkg::mem_size_e  size;
  lsu_pkg::xlen_t      wdata;
  lsu_pkg::strb_t      wstrb;

  assign opcode   = inst_i[6:0];
  assign funct3   = inst_i[14:12];
  assign is_load  = (opcode == `OPC_LOAD);
  assign is_store = (opcode == `OPC_STORE);

  // S-type splits the immediate around the rd field.
  assign imm  = is_store ? {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]}
                         : {{20{inst_i[31]}}, inst_i[31:20]};
  assign addr = rs1_i + imm;

  always_comb begin
    legal = 1'b1;
    size  = lsu_pkg::SZ_WORD;
    if (is_load) begin
      case (funct3)
        `F3_LB, `F3_LBU: size = lsu_pkg::SZ_BYTE;
        `F3_LH, `F3_LHU: size = lsu_pkg::SZ_HALF;
        `F3_LW:          size = lsu_pkg::SZ_WORD;
        default:         legal = 1'b0;
      endcase
    end else if (is_store) begin
      case (funct3)
        `F3_SB:  size = lsu_pkg::SZ_BYTE;
        `F3_SH:  size = lsu_pkg::SZ_HALF;
        `F3_SW:  size = lsu_pkg::SZ_WORD;
        default: legal = 1'b0;
      endcase
    end else begin
      legal = 1'b0;  // Not a memory opcode.
    end
  end

  assign misaligned = ((size == lsu_pkg::SZ_HALF) && addr[0]) ||
                      ((size == lsu_pkg::SZ_WORD) && (addr[1:0] != 2'b00));

  // Replicate store data so every lane carries it; the strobe picks one.
  always_comb begin
    case (size)
      lsu_pkg::SZ_BYTE: begin
        wdata = {4{rs2_i[7:0]}};
        wstrb = 4'b0001 << addr[1:0];
      end
      lsu_pkg::SZ_HALF: begin
        wdata = {2{rs2_i[15:0]}};
        wstrb = 4'b0011 << {addr[1], 1'b0};
      end
      default: begin
        wdata = rs2_i;
        wstrb = 4'hf;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state     <= lsu_pkg::D_IDLE;
      cmd_ack_o <= 1'b0;
      op.valid  <= 1'b0;
    end else begin
      op.valid <= 1'b0;
      case (state)
        lsu_pkg::D_IDLE: if (cmd_req_i) begin
          state    <= lsu_pkg::D_BUSY;
          op.valid <= 1'b1;
        end
        lsu_pkg::D_BUSY: if (done_i) begin
          state     <= lsu_pkg::D_ACK;
          cmd_ack_o <= 1'b1;
        end
        lsu_pkg::D_ACK: if (!cmd_req_i) begin  // Requester released.
          state     <= lsu_pkg::D_IDLE;
          cmd_ack_o <= 1'b0;
        end
        default: state <= lsu_pkg::D_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == lsu_pkg::D_IDLE && cmd_req_i) begin
      op.is_store <= is_store;
      op.addr     <= addr;
      op.wdata    <= wdata;
      op.wstrb    <= is_store ? wstrb : 4'h0;
      op.size     <= size;
      op.uns      <= funct3[2];
      op.err      <= !legal || misaligned;
    end
  end

  a_no_ack_busy: assert property (@(posedge clk) disable iff (!rst)
    state == lsu_pkg::D_BUSY |-> !cmd_ack_o)
    else $error("cmd_ack_o high while an operation is in flight");

endmodule

`default_nettype wire

// File: design/lsu_execute.sv
`default_nettype none

module lsu_execute (
  input  logic        clk,
  input  logic        rst,
  lsu_op_if.consumer  op,
  mem_bus_if.master   bus,
  lsu_res_if.producer res
);

  lsu_pkg::exec_state_e state;
  lsu_pkg::addr_t       word_addr;

  assign word_addr = {op.addr[31:2], 2'b00};

  // Always ready for the response once the request is out.
  assign bus.rready = (state == lsu_pkg::E_RDATA);
  assign bus.bready = (state == lsu_pkg::E_WRESP);
  assign res.valid  = (state == lsu_pkg::E_FINISH);

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state       <= lsu_pkg::E_IDLE;
      bus.arvalid <= 1'b0;
      bus.awvalid <= 1'b0;
      bus.wvalid  <= 1'b0;
      res.err     <= 1'b0;
    end else begin
      case (state)
        lsu_pkg::E_IDLE: begin
          if (op.valid) begin
            res.err <= op.err;
            if (op.err) begin
              state <= lsu_pkg::E_FINISH;  // No bus access at all.
            end else if (op.is_store) begin
              bus.awvalid <= 1'b1;
              bus.wvalid  <= 1'b1;
              state       <= lsu_pkg::E_WRITE;
            end else begin
              bus.arvalid <= 1'b1;
              state       <= lsu_pkg::E_RADDR;
            end
          end
        end
        lsu_pkg::E_RADDR: begin
          if (bus.arvalid && bus.arready) begin
            bus.arvalid <= 1'b0;
            state       <= lsu_pkg::E_RDATA;
          end
        end
        lsu_pkg::E_RDATA: begin
          if (bus.rvalid) begin
            res.err <= bus.rresp[1];  // SLVERR and DECERR both set bit 1.
            state   <= lsu_pkg::E_FINISH;
          end
        end
        lsu_pkg::E_WRITE: begin
          // Each valid drops on its own handshake.
          if (bus.awready) bus.awvalid <= 1'b0;
          if (bus.wready)  bus.wvalid  <= 1'b0;
          if ((!bus.awvalid || bus.awready) && (!bus.wvalid || bus.wready)) begin
            state <= lsu_pkg::E_WRESP;
          end
        end
        lsu_pkg::E_WRESP: begin
          if (bus.bvalid) begin
            res.err <= bus.bresp[1];
            state   <= lsu_pkg::E_FINISH;
          end
        end
        default: state <= lsu_pkg::E_IDLE;  // E_FINISH lasts one cycle.
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == lsu_pkg::E_IDLE && op.valid) begin
      bus.araddr  <= word_addr;
      bus.awaddr  <= word_addr;
      bus.wdata   <= op.wdata;
      bus.wstrb   <= op.wstrb;
      res.addr_lo <= op.addr[1:0];
      res.size    <= op.size;
      res.uns     <= op.uns;
      res.rword   <= '0;  // Stores and errors return zero.
    end else if (state == lsu_pkg::E_RDATA && bus.rvalid) begin
      res.rword <= bus.rdata;
    end
  end

  a_ar_hold: assert property (@(posedge clk) disable iff (!rst)
    bus.arvalid && !bus.arready |=> bus.arvalid && $stable(bus.araddr))
    else $error("arvalid or araddr changed before arready");

  a_one_op: assert property (@(posedge clk) disable iff (!rst)
    op.valid |-> state == lsu_pkg::E_IDLE)
    else $error("new operation while execute is busy");

endmodule

`default_nettype wire

// File: design/lsu_result.sv
`default_nettype none

module lsu_result (
  input  logic           clk,
  input  logic           rst,
  lsu_res_if.consumer    res,
  output lsu_pkg::xlen_t rdata_o,
  output logic           err_o,
  output logic           done_o
);

  lsu_pkg::xlen_t shifted;
  lsu_pkg::xlen_t ext;

  // Bring the addressed lane down to bit 0.
  assign shifted = res.rword >> {res.addr_lo, 3'b000};

  always_comb begin
    case (res.size)
      lsu_pkg::SZ_BYTE:
        ext = res.uns ? {24'h0, shifted[7:0]} : {{24{shifted[7]}}, shifted[7:0]};
      lsu_pkg::SZ_HALF:
        ext = res.uns ? {16'h0, shifted[15:0]} : {{16{shifted[15]}}, shifted[15:0]};
      default:
        ext = shifted;  // Word, offset is zero.
    endcase
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      rdata_o <= '0;
      err_o   <= 1'b0;
      done_o  <= 1'b0;
    end else begin
      done_o <= res.valid;
      if (res.valid) begin
        err_o   <= res.err;
        rdata_o <= res.err ? '0 : ext;  // An error never leaks data.
      end
    end
  end

endmodule

`default_nettype wire

// File: design/dsram.sv
`include "lsu_consts.svh"
`default_nettype none

module dsram (
  input  logic     clk,
  input  logic     rst,
  mem_bus_if.slave bus
);

  localparam int unsigned DEPTH = 1 << `DSRAM_AW;

  lsu_pkg::xlen_t         mem [DEPTH];
  lsu_pkg::dsram_state_e  state, next_state;
  logic [3:0]             rc_cnt;  // Read latency.
  logic [3:0]             wc_cnt;  // Write latency.
  lsu_pkg::addr_t         waddr_q;
  logic                   rd_hit, wr_hit;
  logic [`DSRAM_AW-1:0]   rd_idx, wr_idx;

  // Any bit above the word index puts the address out of range.
  assign rd_hit = (bus.araddr[31:`DSRAM_AW+2] == '0);
  assign wr_hit = (waddr_q[31:`DSRAM_AW+2] == '0);
  assign rd_idx = bus.araddr[`DSRAM_AW+1:2];
  assign wr_idx = waddr_q[`DSRAM_AW+1:2];

  assign bus.arready = (state == lsu_pkg::IDLE);
  assign bus.awready = (state == lsu_pkg::IDLE);
  assign bus.wready  = (state == lsu_pkg::WAIT_WVALID);

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state <= lsu_pkg::IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      lsu_pkg::IDLE: begin
        if (bus.arvalid) begin
          next_state = lsu_pkg::READ;  // Reads win over writes.
        end else if (bus.awvalid) begin
          next_state = lsu_pkg::WAIT_WVALID;
        end
      end
      lsu_pkg::READ:
        if (rc_cnt >= 4'(`RC_LAT)) next_state = lsu_pkg::WAIT_RREADY;
      lsu_pkg::WAIT_RREADY:
        if (bus.rready) next_state = lsu_pkg::IDLE;
      lsu_pkg::WAIT_WVALID:
        if (bus.wvalid) next_state = lsu_pkg::WRITE;
      lsu_pkg::WRITE:
        if (wc_cnt >= 4'(`WC_LAT)) next_state = lsu_pkg::WAIT_BREADY;
      lsu_pkg::WAIT_BREADY:
        if (bus.bready) next_state = lsu_pkg::IDLE;
      default: next_state = lsu_pkg::IDLE;
    endcase
  end

  // Counters run only while in their own state.
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      rc_cnt <= 4'h0;
      wc_cnt <= 4'h0;
    end else begin
      rc_cnt <= (state == lsu_pkg::READ)  ? rc_cnt + 4'h1 : 4'h0;
      wc_cnt <= (state == lsu_pkg::WRITE) ? wc_cnt + 4'h1 : 4'h0;
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      bus.rvalid <= 1'b0;
      bus.bvalid <= 1'b0;
    end else begin
      if (state == lsu_pkg::READ && next_state == lsu_pkg::WAIT_RREADY) begin
        bus.rvalid <= 1'b1;
      end else if (bus.rvalid && bus.rready) begin
        bus.rvalid <= 1'b0;
      end
      if (state == lsu_pkg::WRITE && next_state == lsu_pkg::WAIT_BREADY) begin
        bus.bvalid <= 1'b1;
      end else if (bus.bvalid && bus.bready) begin
        bus.bvalid <= 1'b0;
      end
    end
  end

  // Array access and response codes.
  always_ff @(posedge clk) begin
    if (bus.arvalid && bus.arready) begin
      bus.rdata <= rd_hit ? mem[rd_idx] : '0;
      bus.rresp <= rd_hit ? `RESP_OKAY : `RESP_SLVERR;
    end
    if (bus.awvalid && bus.awready && !bus.arvalid) begin
      waddr_q <= bus.awaddr;
    end
    if (bus.wvalid && bus.wready) begin
      bus.bresp <= wr_hit ? `RESP_OKAY : `RESP_SLVERR;
      if (wr_hit) begin
        for (int b = 0; b < 4; b++) begin
          if (bus.wstrb[b]) mem[wr_idx][8*b +: 8] <= bus.wdata[8*b +: 8];
        end
      end
    end
  end

  a_bvalid_state: assert property (@(posedge clk) disable iff (!rst)
    bus.bvalid |-> state == lsu_pkg::WAIT_BREADY)
    else $error("bvalid raised outside WAIT_BREADY");

endmodule

`default_nettype wire

// File: design/lsu_top.sv
`default_nettype none

module lsu_top (
  input  logic           clk,
  input  logic           rst,
  input  logic           cmd_req_i,
  output logic           cmd_ack_o,
  input  lsu_pkg::inst_t inst_i,
  input  lsu_pkg::xlen_t rs1_i,
  input  lsu_pkg::xlen_t rs2_i,
  output lsu_pkg::xlen_t rdata_o,
  output logic           err_o
);

  logic done;  // Result registered, decode may acknowledge.

  lsu_op_if  op_if ();
  lsu_res_if res_if ();
  mem_bus_if bus_if ();

  lsu_decode u_decode (
    .clk       (clk),
    .rst       (rst),
    .cmd_req_i (cmd_req_i),
    .cmd_ack_o (cmd_ack_o),
    .inst_i    (inst_i),
    .rs1_i     (rs1_i),
    .rs2_i     (rs2_i),
    .done_i    (done),
    .op        (op_if.producer)
  );

  lsu_execute u_execute (
    .clk (clk),
    .rst (rst),
    .op  (op_if.consumer),
    .bus (bus_if.master),
    .res (res_if.producer)
  );

  lsu_result u_result (
    .clk     (clk),
    .rst     (rst),
    .res     (res_if.consumer),
    .rdata_o (rdata_o),
    .err_o   (err_o),
    .done_o  (done)
  );

  dsram u_dsram (
    .clk (clk),
    .rst (rst),
    .bus (bus_if.slave)
  );

endmodule

`default_nettype wire

// File: dv/lsu_tb.sv
`include "lsu_consts.svh"
`default_nettype none

module lsu_tb;

  localparam int N_CMDS = 100;  // Commands issued over all six tests.

  logic           clk;
  logic           rst;
  logic           cmd_req;
  logic           cmd_ack;
  lsu_pkg::inst_t inst;
  lsu_pkg::xlen_t rs1, rs2;
  lsu_pkg::xlen_t rdata;
  logic           err;

  logic [7:0]     ref_mem [0:1023];  // Little-endian byte image of the SRAM.
  lsu_pkg::xlen_t rng = 32'd4;
  int             errors = 0;
  int             checks = 0;

  lsu_top UUT (
    .clk       (clk),
    .rst       (rst),
    .cmd_req_i (cmd_req),
    .cmd_ack_o (cmd_ack),
    .inst_i    (inst),
    .rs1_i     (rs1),
    .rs2_i     (rs2),
    .rdata_o   (rdata),
    .err_o     (err)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic lsu_pkg::xlen_t xorshift(input lsu_pkg::xlen_t x);
    lsu_pkg::xlen_t y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  // Base register is x1, data or destination register is x2.
  function automatic lsu_pkg::inst_t load_insn(input logic [2:0] f3, input logic [11:0] imm);
    return {imm, 5'd1, f3, 5'd2, `OPC_LOAD};
  endfunction

  function automatic lsu_pkg::inst_t store_insn(input logic [2:0] f3, input logic [11:0] imm);
    return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], `OPC_STORE};
  endfunction

  function automatic lsu_pkg::xlen_t fill_word(input lsu_pkg::addr_t a);
    return (a * 32'h9E37_79B9) ^ 32'h5A5A_0F0F;
  endfunction

  function automatic void model_store(input lsu_pkg::addr_t a, input logic [1:0] sz,
                                      input lsu_pkg::xlen_t d);
    for (int i = 0; i < (1 << sz); i++) ref_mem[a + i] = d[8*i +: 8];
  endfunction

  // Gather the bytes, then extend from the top loaded bit unless funct3[2] is set.
  function automatic lsu_pkg::xlen_t model_load(input lsu_pkg::addr_t a, input logic [2:0] f3);
    lsu_pkg::xlen_t w;
    int             nb;
    w  = '0;
    nb = 1 << f3[1:0];
    for (int i = 0; i < nb; i++) w[8*i +: 8] = ref_mem[a + i];
    if (!f3[2] && w[8*nb-1]) begin
      for (int i = nb; i < 4; i++) w[8*i +: 8] = 8'hff;
    end
    return w;
  endfunction

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s: got %h, expected %h", $time, msg, got, exp);
    end
  endtask

  // Full four-phase exchange, with the ack rules checked on the way.
  task automatic do_cmd(input lsu_pkg::inst_t i, input lsu_pkg::xlen_t a,
                        input lsu_pkg::xlen_t b, output lsu_pkg::xlen_t rd, output logic e);
    @(posedge clk);
    check_eq(cmd_ack, 1'b0, "ack low before request");
    inst    <= i;
    rs1     <= a;
    rs2     <= b;
    cmd_req <= 1'b1;
    do @(posedge clk); while (cmd_ack !== 1'b1);
    rd = rdata;
    e  = err;
    @(posedge clk);
    check_eq(cmd_ack, 1'b1, "ack held while req high");
    cmd_req <= 1'b0;
    do @(posedge clk); while (cmd_ack !== 1'b0);
  endtask

  task automatic run_load(input logic [2:0] f3, input lsu_pkg::addr_t a, input logic exp_err,
                          input string msg);
    lsu_pkg::xlen_t rd;
    logic           e;
    rng = xorshift(rng);
    do_cmd(load_insn(f3, 12'hffc), a + 32'd4, rng, rd, e);  // Immediate of -4.
    check_eq(e, exp_err, msg);
    check_eq(rd, exp_err ? 32'h0 : model_load(a, f3), msg);
  endtask

  task automatic run_store(input logic [2:0] f3, input lsu_pkg::addr_t a, input lsu_pkg::xlen_t d,
                           input logic exp_err, input string msg);
    lsu_pkg::xlen_t rd;
    logic           e;
    do_cmd(store_insn(f3, 12'd8), a - 32'd8, d, rd, e);
    check_eq(e, exp_err, msg);
    check_eq(rd, 32'h0, msg);  // Stores return no data.
    if (!exp_err) model_store(a, f3[1:0], d);
  endtask

  task automatic report_test(input string name, input int errors_before);
    $display("test %s finished with %0d errors", name, errors - errors_before);
  endtask

  task automatic word_round_trip();
    lsu_pkg::addr_t addrs [4] = '{32'h000, 32'h004, 32'h100, 32'h3fc};
    int             e0;
    e0 = errors;
    foreach (addrs[k]) begin
      rng = xorshift(rng);
      run_store(`F3_SW, addrs[k], rng, 1'b0, "word store");
    end
    foreach (addrs[k]) run_load(`F3_LW, addrs[k], 1'b0, "word load");
    report_test("word_round_trip", e0);
  endtask

  task automatic sub_word_access();
    int e0;
    e0 = errors;
    run_store(`F3_SW, 32'h040, 32'h8f7f_0180, 1'b0, "pattern store");
    run_store(`F3_SB, 32'h041, 32'h1234_56c5, 1'b0, "byte store");
    run_store(`F3_SH, 32'h042, 32'habcd_7e91, 1'b0, "half store");
    for (int lane = 0; lane < 4; lane++) begin
      run_load(`F3_LB, 32'h040 + lane, 1'b0, "lb lane");
      run_load(`F3_LBU, 32'h040 + lane, 1'b0, "lbu lane");
    end
    for (int lane = 0; lane < 4; lane += 2) begin
      run_load(`F3_LH, 32'h040 + lane, 1'b0, "lh lane");
      run_load(`F3_LHU, 32'h040 + lane, 1'b0, "lhu lane");
    end
    run_load(`F3_LW, 32'h040, 1'b0, "merged word");
    report_test("sub_word_access", e0);
  endtask

  task automatic misaligned_access();
    int e0;
    e0 = errors;
    run_store(`F3_SW, 32'h080, 32'h1357_9bdf, 1'b0, "base word");
    run_load(`F3_LH, 32'h081, 1'b1, "misaligned lh");
    run_load(`F3_LW, 32'h082, 1'b1, "misaligned lw");
    run_load(`F3_LHU, 32'h083, 1'b1, "misaligned lhu");
    run_store(`F3_SH, 32'h083, 32'hffff_ffff, 1'b1, "misaligned sh");
    run_store(`F3_SW, 32'h081, 32'h0000_0000, 1'b1, "misaligned sw");
    run_load(`F3_LW, 32'h080, 1'b0, "word after misaligned");
    report_test("misaligned_access", e0);
  endtask

  task automatic out_of_range();
    int e0;
    e0 = errors;
    run_load(`F3_LW, 32'h400, 1'b1, "lw at 1 KiB");
    run_load(`F3_LBU, 32'h401, 1'b1, "lbu above 1 KiB");
    run_store(`F3_SW, 32'h400, 32'hcafe_f00d, 1'b1, "sw at 1 KiB");
    run_store(`F3_SB, 32'h1000_0003, 32'h0000_00aa, 1'b1, "sb far above");
    run_store(`F3_SH, 32'hffff_fffe, 32'h0000_5555, 1'b1, "sh at top");
    run_load(`F3_LW, 32'h000, 1'b0, "word 0 unchanged");  // An aliased write would land here.
    run_load(`F3_LW, 32'h3fc, 1'b0, "last word unchanged");
    report_test("out_of_range", e0);
  endtask

  task automatic illegal_inst();
    int             e0;
    lsu_pkg::inst_t bad;
    lsu_pkg::xlen_t rd;
    logic           e;
    e0  = errors;
    bad = store_insn(`F3_SW, 12'd0);
    bad[6:0] = 7'b0110011;  // Register ALU opcode.
    do_cmd(bad, 32'h100, 32'hdead_beef, rd, e);
    check_eq(e, 1'b1, "illegal opcode");
    check_eq(rd, 32'h0, "illegal opcode");
    run_load(3'b011, 32'h100, 1'b1, "load funct3 011");
    run_load(3'b110, 32'h100, 1'b1, "load funct3 110");
    run_load(3'b111, 32'h100, 1'b1, "load funct3 111");
    run_store(3'b100, 32'h100, 32'hdead_beef, 1'b1, "store funct3 100");
    run_load(`F3_LW, 32'h100, 1'b0, "word after illegal");
    report_test("illegal_inst", e0);
  endtask

  task automatic random_sequence();
    int             e0;
    logic [1:0]     sz;
    lsu_pkg::addr_t a;
    e0 = errors;
    for (int w = 0; w < 16; w++) begin
      run_store(`F3_SW, 32'h200 + 4*w, fill_word(32'h200 + 4*w), 1'b0, "fill");
    end
    for (int n = 0; n < 40; n++) begin
      rng = xorshift(rng);
      sz  = (rng[2:1] == 2'd3) ? 2'd2 : rng[2:1];
      a   = 32'h200 + {rng[6:3], 2'b00};
      if (sz == 2'd0) a[1:0] = rng[8:7];
      else if (sz == 2'd1) a[1] = rng[8];
      if (rng[0]) begin
        run_store({1'b0, sz}, a, xorshift(rng), 1'b0, "random store");
      end else begin
        run_load({rng[9] && sz != 2'd2, sz}, a, 1'b0, "random load");
      end
    end
    report_test("random_sequence", e0);
  endtask

  initial begin
    rst     = 1'b0;
    cmd_req = 1'b0;
    inst    = '0;
    rs1     = '0;
    rs2     = '0;
    repeat (3) @(posedge clk);
    rst <= 1'b1;
    word_round_trip();
    sub_word_access();
    misaligned_access();
    out_of_range();
    illegal_inst();
    random_sequence();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // Bounds the run at 400 cycles per command.
  initial begin
    repeat (400 * N_CMDS + 10) @(posedge clk);
    $display("watchdog timeout: DUT did not acknowledge");
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
+incdir+design
design/lsu_pkg.sv
design/lsu_ifs.sv
design/lsu_decode.sv
design/lsu_execute.sv
design/lsu_result.sv
design/dsram.sv
design/lsu_top.sv
dv/lsu_tb.sv
